/* datapath_consts.svh */
`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

// word size shared by the ALU and both operand banks
`define WORD_WIDTH      16

// instruction field widths, op sits at the top of the word
`define OPCODE_WIDTH    4
`define D_WIDTH         12
`define AB_WIDTH        10

// each bank holds 2**AB_WIDTH words
`define BANK_DEPTH      1024

// write address map in D space
// bank A takes the first BANK_DEPTH words and bank B the next BANK_DEPTH
// anything at or above B_WRITE_BASE + BANK_DEPTH lands in no bank
`define A_WRITE_BASE    0
`define B_WRITE_BASE    1024

`endif

/* datapath_pkg.sv */
`default_nettype none

`include "datapath_consts.svh"

package datapath_pkg;

    // codes 8 to 15 are not named and execute as a nop
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        OP_ADD  = 0,
        OP_SUB  = 1,
        OP_AND  = 2,
        OP_OR   = 3,
        OP_XOR  = 4,
        OP_PASS = 5,
        OP_MUL  = 6,
        OP_NOP  = 7
    } opcode_e;

    // issued instruction word, 36 bits with op in the top bits
    typedef struct packed {
        opcode_e                op;
        logic [`D_WIDTH-1:0]    d;
        logic [`AB_WIDTH-1:0]   a;
        logic [`AB_WIDTH-1:0]   b;
    } instr_t;

    // registered ALU output, op and D travel with the result to the write stage
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] result;
        opcode_e                op;
        logic [`D_WIDTH-1:0]    d;
        logic                   carry;
    } alu_out_t;

endpackage

`default_nettype wire

/* operand_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module operand_ram #(
    parameter int WIDTH = `WORD_WIDTH,
    parameter int DEPTH = `BANK_DEPTH
) (
    input  wire                         clock,

    input  wire                         wren,
    input  wire [$clog2(DEPTH)-1:0]     write_addr,
    input  wire [WIDTH-1:0]             write_data,

    input  wire [$clog2(DEPTH)-1:0]     read_addr,
    output logic [WIDTH-1:0]            read_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // banks power up cleared, there is no reset on the array
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // a read of the address being written returns the word from before the write
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module alu
    import datapath_pkg::*;
(
    input  wire                         clock,
    input  wire                         rst_n,

    // issue side, sampled at the same edge as the bank read address
    input  wire opcode_e                op_in,
    input  wire [`D_WIDTH-1:0]          d_in,
    input  wire                         c_in,

    // bank read data, valid one cycle after issue
    input  wire [`WORD_WIDTH-1:0]       a,
    input  wire [`WORD_WIDTH-1:0]       b,

    output alu_out_t                    alu_out
);

    opcode_e                op_q;
    logic [`D_WIDTH-1:0]    d_q;
    logic                   c_q;

    logic [`WORD_WIDTH:0]   sum;
    logic [`WORD_WIDTH-1:0] result_next;
    logic                   carry_next;

    // the op has to be a nop coming out of reset so nothing gets written
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            op_q <= OP_NOP;
        end else begin
            op_q <= op_in;
        end
    end

    // D and carry-in follow the op through the bank read stage
    always_ff @(posedge clock) begin
        d_q <= d_in;
        c_q <= c_in;
    end

    // 17-bit add so the top bit is the carry out
    assign sum = {1'b0, a} + {1'b0, b} + {{`WORD_WIDTH{1'b0}}, c_q};

    always_comb begin
        result_next = '0;
        carry_next  = 1'b0;
        case (op_q)
            OP_ADD: begin
                result_next = sum[`WORD_WIDTH-1:0];
                carry_next  = sum[`WORD_WIDTH];
            end
            OP_SUB: begin
                result_next = a - b;
                // borrow out of the subtract
                carry_next  = (b > a);
            end
            OP_AND: begin
                result_next = a & b;
            end
            OP_OR: begin
                result_next = a | b;
            end
            OP_XOR: begin
                result_next = a ^ b;
            end
            OP_PASS: begin
                result_next = a;
            end
            OP_MUL: begin
                // only the low half of the product is kept
                result_next = a * b;
            end
            default: begin
                result_next = '0;
                carry_next  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            alu_out.result <= '0;
            alu_out.op     <= OP_NOP;
            alu_out.d      <= '0;
            alu_out.carry  <= 1'b0;
        end else begin
            alu_out.result <= result_next;
            alu_out.op     <= op_q;
            alu_out.d      <= d_q;
            alu_out.carry  <= carry_next;
        end
    end

endmodule

`default_nettype wire

/* bank_write_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module bank_write_decode
    import datapath_pkg::*;
(
    input  wire alu_out_t               alu_out,

    // external strobes that force a bank write regardless of op and D
    input  wire                         a_wren_other,
    input  wire                         b_wren_other,

    output logic                        a_wren,
    output logic                        b_wren,
    output logic [`AB_WIDTH-1:0]        write_addr,
    output logic [`WORD_WIDTH-1:0]      write_data
);

    // D ranges of the two banks, upper bound exclusive
    localparam int A_LO = `A_WRITE_BASE;
    localparam int A_HI = `A_WRITE_BASE + `BANK_DEPTH;
    localparam int B_LO = `B_WRITE_BASE;
    localparam int B_HI = `B_WRITE_BASE + `BANK_DEPTH;

    logic writing_op;
    logic a_hit;
    logic b_hit;

    // nop and the unnamed codes never write
    assign writing_op = alu_out.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
                                           OP_XOR, OP_PASS, OP_MUL};

    assign a_hit = (int'(alu_out.d) >= A_LO) && (int'(alu_out.d) < A_HI);
    assign b_hit = (int'(alu_out.d) >= B_LO) && (int'(alu_out.d) < B_HI);

    assign a_wren = (writing_op && a_hit) || a_wren_other;
    assign b_wren = (writing_op && b_hit) || b_wren_other;

    // both banks see the same offset and data, only the enables differ
    assign write_addr = alu_out.d[`AB_WIDTH-1:0];
    assign write_data = alu_out.result;

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module datapath
    import datapath_pkg::*;
(
    input  wire                         clock,
    input  wire                         rst_n,

    input  wire instr_t                 instr,
    input  wire                         c_in,

    input  wire                         a_wren_other,
    input  wire                         b_wren_other,

    output wire alu_out_t               alu_out,
    output wire [`WORD_WIDTH-1:0]       a_read_data
);

    wire [`WORD_WIDTH-1:0]  b_read_data;

    wire                    a_wren;
    wire                    b_wren;
    wire [`AB_WIDTH-1:0]    write_addr;
    wire [`WORD_WIDTH-1:0]  write_data;

    operand_ram #(
        .WIDTH          (`WORD_WIDTH),
        .DEPTH          (`BANK_DEPTH)
    ) a_bank (
        .clock          (clock),
        .wren           (a_wren),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .read_addr      (instr.a),
        .read_data      (a_read_data)
    );

    operand_ram #(
        .WIDTH          (`WORD_WIDTH),
        .DEPTH          (`BANK_DEPTH)
    ) b_bank (
        .clock          (clock),
        .wren           (b_wren),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .read_addr      (instr.b),
        .read_data      (b_read_data)
    );

    alu alu (
        .clock          (clock),
        .rst_n          (rst_n),
        .op_in          (instr.op),
        .d_in           (instr.d),
        .c_in           (c_in),
        .a              (a_read_data),
        .b              (b_read_data),
        .alu_out        (alu_out)
    );

    // write-back closes the loop two edges after issue
    bank_write_decode bank_write_decode (
        .alu_out        (alu_out),
        .a_wren_other   (a_wren_other),
        .b_wren_other   (b_wren_other),
        .a_wren         (a_wren),
        .b_wren         (b_wren),
        .write_addr     (write_addr),
        .write_data     (write_data)
    );

endmodule

`default_nettype wire

/* datapath_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath_assertions
    import datapath_pkg::*;
(
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire                         a_wren,
    input  wire                         b_wren,
    input  wire                         a_wren_other,
    input  wire                         b_wren_other,
    input  wire alu_out_t               alu_out
);

    // read by the testbench when it decides the final result
    int failures = 0;

    // the two D ranges are disjoint, so only a force strobe can enable both banks
    a_single_bank: assert property (@(posedge clock) disable iff (!rst_n)
        (a_wren && b_wren) |-> (a_wren_other || b_wren_other))
    else begin
        $error("both bank write enables set without a force strobe");
        failures++;
    end

    // nop and the unnamed codes 8 to 15 write nothing on their own
    a_nop_quiet: assert property (@(posedge clock) disable iff (!rst_n)
        (alu_out.op >= OP_NOP) |-> ((!a_wren || a_wren_other) && (!b_wren || b_wren_other)))
    else begin
        $error("bank write enable raised by a nop alu output");
        failures++;
    end

    a_reset_nop: assert property (@(posedge clock)
        $rose(rst_n) |-> (alu_out.op == OP_NOP) ##1 (alu_out.op == OP_NOP))
    else begin
        $error("alu output op is not nop right after reset release");
        failures++;
    end

endmodule

bind datapath datapath_assertions checks (
    .clock          (clock),
    .rst_n          (rst_n),
    .a_wren         (a_wren),
    .b_wren         (b_wren),
    .a_wren_other   (a_wren_other),
    .b_wren_other   (b_wren_other),
    .alu_out        (alu_out)
);

`default_nettype wire

/* tb_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module tb_datapath
    import datapath_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 6000;

    logic                       clock;
    logic                       rst_n;
    instr_t                     instr;
    logic                       c_in;
    logic                       a_wren_other;
    logic                       b_wren_other;
    alu_out_t                   alu_out;
    logic [`WORD_WIDTH-1:0]     a_read_data;

    integer                     seed;
    int                         cycle_count;
    string                      cur_test;
    int                         test_errors;
    int                         total_errors;
    int                         tests_ok;
    int                         tests_failed;

    // reference state holds the bank contents and the two pipeline stages
    logic [`WORD_WIDTH-1:0]     model_a [`BANK_DEPTH];
    logic [`WORD_WIDTH-1:0]     model_b [`BANK_DEPTH];
    opcode_e                    s1_op;
    logic [`D_WIDTH-1:0]        s1_d;
    logic                       s1_c;
    logic [`WORD_WIDTH-1:0]     s1_ra;
    logic [`WORD_WIDTH-1:0]     s1_rb;
    alu_out_t                   exp_out;
    logic [`WORD_WIDTH-1:0]     exp_read;

    datapath uut (
        .clock          (clock),
        .rst_n          (rst_n),
        .instr          (instr),
        .c_in           (c_in),
        .a_wren_other   (a_wren_other),
        .b_wren_other   (b_wren_other),
        .alu_out        (alu_out),
        .a_read_data    (a_read_data)
    );

    initial begin
        clock = 1'b0;
    end

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic instr_t make_instr(input logic [3:0] op, input logic [11:0] d,
                                          input logic [9:0] a, input logic [9:0] b);
        instr_t ins;
        ins.op = opcode_e'(op);
        ins.d  = d;
        ins.a  = a;
        ins.b  = b;
        return ins;
    endfunction

    // ALU behavior written from the operation table
    function automatic alu_out_t model_alu(input opcode_e op, input logic [11:0] d,
                                           input logic c, input logic [15:0] a,
                                           input logic [15:0] b);
        alu_out_t o;
        int sum;
        logic [31:0] prod;
        o.op     = op;
        o.d      = d;
        o.result = '0;
        o.carry  = 1'b0;
        case (op)
            OP_ADD: begin
                sum = int'(a) + int'(b) + int'(c);
                o.result = sum[15:0];
                o.carry  = sum[16];
            end
            OP_SUB: begin
                sum = int'(a) - int'(b);
                o.result = sum[15:0];
                o.carry  = (sum < 0);
            end
            OP_AND:  o.result = a & b;
            OP_OR:   o.result = a | b;
            OP_XOR:  o.result = a ^ b;
            OP_PASS: o.result = a;
            OP_MUL: begin
                prod = a * b;
                o.result = prod[15:0];
            end
            default: o.result = '0;
        endcase
        return o;
    endfunction

    // one rising edge of the reference reads old data, writes back and advances the stages
    task automatic model_edge(input instr_t ins, input logic c, input logic fa,
                              input logic fb, input logic rst_level);
        logic [15:0] ra;
        logic [15:0] rb;
        logic        writes;
        ra = model_a[ins.a];
        rb = model_b[ins.b];
        writes = (exp_out.op <= OP_MUL);
        if (fa || (writes && exp_out.d < `B_WRITE_BASE)) begin
            model_a[exp_out.d[9:0]] = exp_out.result;
        end
        if (fb || (writes && exp_out.d >= `B_WRITE_BASE
                          && exp_out.d < `B_WRITE_BASE + `BANK_DEPTH)) begin
            model_b[exp_out.d[9:0]] = exp_out.result;
        end
        if (!rst_level) begin
            exp_out = '{result: '0, op: OP_NOP, d: '0, carry: 1'b0};
            s1_op   = OP_NOP;
        end else begin
            exp_out = model_alu(s1_op, s1_d, s1_c, s1_ra, s1_rb);
            s1_op   = ins.op;
        end
        s1_d     = ins.d;
        s1_c     = c;
        s1_ra    = ra;
        s1_rb    = rb;
        exp_read = ra;
    endtask

    task automatic compare_value(input string what,
                                 input logic [$bits(alu_out_t)-1:0] expected,
                                 input logic [$bits(alu_out_t)-1:0] actual);
        if (expected !== actual) begin
            $display("error: %s %s expected %h actual %h", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic run_cycle(input instr_t ins, input logic c, input logic fa, input logic fb);
        instr        = ins;
        c_in         = c;
        a_wren_other = fa;
        b_wren_other = fb;
        @(posedge clock);
        model_edge(ins, c, fa, fb, rst_n);
        #1;
        compare_value("alu_out.result", exp_out.result, alu_out.result);
        compare_value("alu_out.op", exp_out.op, alu_out.op);
        compare_value("alu_out.d", exp_out.d, alu_out.d);
        compare_value("alu_out.carry", exp_out.carry, alu_out.carry);
        compare_value("a_read_data", exp_read, a_read_data);
    endtask

    task automatic drain_pipeline();
        repeat (2) run_cycle(make_instr(OP_NOP, '0, '0, '0), 1'b0, 1'b0, 1'b0);
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_ok++;
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", cur_test, test_errors);
        end
        total_errors += test_errors;
    endtask

    task automatic check_reset();
        logic [31:0] r;
        begin_test("reset");
        repeat (8) run_cycle(make_instr(OP_NOP, '0, '0, '0), 1'b0, 1'b0, 1'b0);
        rst_n = 1'b1;
        repeat (6) begin
            r = next_rand();
            run_cycle(make_instr(OP_NOP, '0, r[9:0], r[19:10]), 1'b0, 1'b0, 1'b0);
            compare_value("alu_out after reset", {16'd0, OP_NOP, 12'd0, 1'b0}, alu_out);
            compare_value("bank word after reset", 0, a_read_data);
        end
        end_test();
    endtask

    task automatic random_alu_run();
        logic [31:0] r;
        logic [31:0] s;
        begin_test("random_alu");
        repeat (1000) begin
            r = next_rand();
            s = next_rand();
            run_cycle(make_instr(r[3:0], r[15:4], r[25:16], s[9:0]), s[10], 1'b0, 1'b0);
        end
        drain_pipeline();
        end_test();
    endtask

    // D range 0 goes to bank A, 1 to bank B, 2 and 3 to neither
    task automatic route_writes();
        logic [31:0] r;
        logic [9:0]  x;
        logic [1:0]  region;
        begin_test("bank_routing");
        for (int t = 0; t < 100; t++) begin
            r = next_rand();
            x = r[9:0];
            region = 2'(t % 3);
            run_cycle(make_instr(r[18:16] % 3'd7, {region, x}, r[29:20], x), r[30],
                      1'b0, 1'b0);
            repeat (2) run_cycle(make_instr(OP_NOP, 12'hfff, x, x), 1'b0, 1'b0, 1'b0);
            run_cycle(make_instr(OP_XOR, 12'hfff, x, x), 1'b0, 1'b0, 1'b0);
        end
        drain_pipeline();
        end_test();
    endtask

    task automatic force_writes();
        logic [31:0] r;
        logic [9:0]  x;
        logic [3:0]  op;
        logic [11:0] d;
        logic        fa;
        logic        fb;
        begin_test("force_write");
        for (int t = 0; t < 100; t++) begin
            r  = next_rand();
            x  = r[9:0];
            fa = r[10];
            fb = r[11] | !r[10];
            if (r[12]) begin
                op = r[13] ? 4'(OP_NOP) : {1'b1, r[16:14]};
                d  = {r[18:17], x};
            end else begin
                op = r[16:14] % 3'd7;
                d  = {1'b1, r[17], x};
            end
            run_cycle(make_instr(op, d, r[28:19], x), r[29], 1'b0, 1'b0);
            run_cycle(make_instr(OP_NOP, 12'hfff, x, x), 1'b0, 1'b0, 1'b0);
            // this edge is the write edge of the instruction issued two cycles back
            run_cycle(make_instr(OP_NOP, 12'hfff, x, x), 1'b0, fa, fb);
            run_cycle(make_instr(OP_XOR, 12'hfff, x, x), 1'b0, 1'b0, 1'b0);
        end
        drain_pipeline();
        end_test();
    endtask

    task automatic hazard_chains();
        logic [31:0] r;
        logic [9:0]  x;
        logic [9:0]  bsel;
        logic        c;
        logic [15:0] old_word;
        logic [15:0] new_word;
        alu_out_t    w;
        begin_test("hazard");
        for (int spacing = 1; spacing <= 3; spacing++) begin
            for (int n = 0; n < 40; n++) begin
                r        = next_rand();
                x        = r[9:0];
                bsel     = r[19:10];
                c        = r[20];
                old_word = model_a[x];
                w        = model_alu(OP_ADD, {2'b00, x}, c, model_a[x], model_b[bsel]);
                new_word = w.result;
                run_cycle(make_instr(OP_ADD, {2'b00, x}, x, bsel), c, 1'b0, 1'b0);
                for (int k = 1; k < spacing; k++) begin
                    run_cycle(make_instr(OP_NOP, '0, '0, '0), 1'b0, 1'b0, 1'b0);
                end
                run_cycle(make_instr(OP_PASS, 12'hfff, x, r[30:21]), 1'b0, 1'b0, 1'b0);
                compare_value("dependent read", (spacing == 3) ? new_word : old_word,
                              a_read_data);
                drain_pipeline();
            end
        end
        end_test();
    endtask

    initial begin
        seed         = 32'hfe046e76;
        cycle_count  = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_ok     = 0;
        tests_failed = 0;
        cur_test     = "setup";
        rst_n        = 1'b0;
        c_in         = 1'b0;
        a_wren_other = 1'b0;
        b_wren_other = 1'b0;
        instr        = make_instr(OP_NOP, '0, '0, '0);
        for (int i = 0; i < `BANK_DEPTH; i++) begin
            model_a[i] = '0;
            model_b[i] = '0;
        end
        s1_op   = OP_NOP;
        s1_d    = '0;
        s1_c    = 1'b0;
        s1_ra   = '0;
        s1_rb   = '0;
        exp_out = '{result: '0, op: OP_NOP, d: '0, carry: 1'b0};

        check_reset();
        random_alu_run();
        route_writes();
        force_writes();
        hazard_chains();

        $display("tests run %0d, ok %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 tests_ok + tests_failed, tests_ok, tests_failed, total_errors,
                 uut.checks.failures);
        if (tests_failed == 0 && uut.checks.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* datapath.f */
+incdir+.
datapath_pkg.sv
operand_ram.sv
alu.sv
bank_write_decode.sv
datapath.sv
datapath_assertions.sv
tb_datapath.sv
